// ==== wisc_config.svh ====
// Datapath and bus sizes
`ifndef WISC_CONFIG_SVH
`define WISC_CONFIG_SVH

`define DATA_W 16
`define REG_COUNT 8
`define REG_AW 3
`define WB_AW 4

`endif

// ==== isaPkg.sv ====
// Instruction set definitions
package isaPkg;

	// Opcode map, one row per group of four
	typedef enum logic [4:0] {
		opHalt, opNop, opSiic, opRti,
		opJ, opJr, opJal, opJalr,
		opAddi, opSubi, opXori, opAndi,
		opBeqz, opBnez, opBltz, opBgez,
		opSt, opLd, opSlbi, opStu,
		opRoli, opSlli, opRori, opSrli,
		opLbi, opBtr, opShiftR, opAluR,
		opSeq, opSlt, opSle, opSco
	} opcode_e;

	typedef struct packed {
		opcode_e opcode;
		logic [2:0] rs;
		logic [2:0] rd;
		logic [4:0] imm5;
	} iOneFmt_t;

	typedef struct packed {
		opcode_e opcode;
		logic [2:0] rs;
		logic [2:0] rt;
		logic [2:0] rd;
		logic [1:0] func;
	} rFmt_t;

	typedef struct packed {
		opcode_e opcode;
		logic [2:0] rs;
		logic [7:0] imm8;
	} iTwoFmt_t;

	// One word, three field layouts
	typedef union packed {
		iOneFmt_t iOne;
		rFmt_t rView;
		iTwoFmt_t iTwo;
	} instr_u;

endpackage

// ==== ctrlPkg.sv ====
// Control signal encodings
package ctrlPkg;

	typedef enum logic [2:0] {
		add, subFromImm, xorOp, andOp, andnOp, sub, passB
	} aluOp_e;

	// Same order as the low opcode bits of the immediate shifts
	typedef enum logic [1:0] {
		rol, sll, ror, srl
	} shiftOp_e;

	typedef enum logic [2:0] {
		alu, shift, setCond, lbi, slbi, btr
	} resSel_e;

	typedef enum logic [1:0] {
		fromRd5, fromRd2, fromRs
	} destSel_e;

endpackage

// ==== control.sv ====
// Opcode decoder
`timescale 1ns/1ps

module control import isaPkg::*, ctrlPkg::*; (
	input instr_u instr,
	output logic regWrite,
	output logic useImm,
	output logic signExt,
	output logic immWide,
	output logic invB,
	output logic halt,
	output logic isSet,
	output aluOp_e aluOp,
	output shiftOp_e shiftOp,
	output resSel_e resSel,
	output destSel_e destSel,
	output logic [1:0] setKind
);

	always_comb begin
		// Anything not listed below is a no-op here
		regWrite = 1'b0;
		useImm = 1'b0;
		signExt = 1'b0;
		immWide = 1'b0;
		invB = 1'b0;
		halt = 1'b0;
		isSet = 1'b0;
		setKind = 2'd0;
		aluOp = passB;
		shiftOp = shiftOp_e'(instr.iOne.opcode[1:0]);
		resSel = alu;
		destSel = fromRd5;
		case (instr.iOne.opcode)
			opHalt: halt = 1'b1;
			opAddi, opSubi: begin
				regWrite = 1'b1;
				useImm = 1'b1;
				signExt = 1'b1;
				aluOp = instr.iOne.opcode[0] ? subFromImm : add;
			end
			// Logic immediates are zero-extended
			opXori, opAndi: begin
				regWrite = 1'b1;
				useImm = 1'b1;
				aluOp = instr.iOne.opcode[0] ? andOp : xorOp;
			end
			opRoli, opSlli, opRori, opSrli: begin
				regWrite = 1'b1;
				useImm = 1'b1;
				resSel = shift;
			end
			opLbi: begin
				regWrite = 1'b1;
				useImm = 1'b1;
				signExt = 1'b1;
				immWide = 1'b1;
				resSel = lbi;
				destSel = fromRs;
			end
			opSlbi: begin
				regWrite = 1'b1;
				useImm = 1'b1;
				immWide = 1'b1;
				resSel = slbi;
				destSel = fromRs;
			end
			opBtr: begin
				regWrite = 1'b1;
				resSel = btr;
				destSel = fromRd2;
			end
			opAluR: begin
				regWrite = 1'b1;
				destSel = fromRd2;
				case (instr.rView.func)
					2'b00: aluOp = add;
					2'b01: aluOp = sub;
					2'b10: aluOp = xorOp;
					default: begin
						aluOp = andnOp;
						invB = 1'b1;
					end
				endcase
			end
			opShiftR: begin
				regWrite = 1'b1;
				destSel = fromRd2;
				resSel = shift;
				shiftOp = shiftOp_e'(instr.rView.func);
			end
			// eq, lt, le, carry-out from the low opcode bits
			opSeq, opSlt, opSle, opSco: begin
				regWrite = 1'b1;
				destSel = fromRd2;
				resSel = setCond;
				isSet = 1'b1;
				setKind = instr.iOne.opcode[1:0];
			end
			default: ;
		endcase
	end

	always_comb begin
		assert (!(halt && regWrite))
			else $error("control: halt decoded together with regWrite");
	end

endmodule

// ==== operandUnit.sv ====
// Register file and immediate extender
`timescale 1ns/1ps
`include "wisc_config.svh"

module operandUnit import isaPkg::*; (
	input logic clk,
	input logic rstN,
	input instr_u instr,
	input logic signExt,
	input logic immWide,
	input logic wrEn,
	input logic [`REG_AW-1:0] wrAddr,
	input logic [`DATA_W-1:0] wrData,
	output logic [`DATA_W-1:0] rsVal,
	output logic [`DATA_W-1:0] rtVal,
	output logic [`DATA_W-1:0] immVal
);

	logic [`DATA_W-1:0] regs [`REG_COUNT];
	logic immSign;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn) begin
			regs[wrAddr] <= wrData;
		end
	end

	assign rsVal = regs[instr.iOne.rs];
	assign rtVal = regs[instr.rView.rt];

	// Sign bit comes from whichever field is in use
	assign immSign = signExt & (immWide ? instr.iTwo.imm8[7] : instr.iOne.imm5[4]);
	assign immVal = immWide ? {{(`DATA_W-8){immSign}}, instr.iTwo.imm8}
		: {{(`DATA_W-5){immSign}}, instr.iOne.imm5};

	assert property (@(posedge clk) disable iff (!rstN) wrEn |-> !$isunknown(wrAddr))
		else $error("operandUnit: write with unknown address");

endmodule

// ==== execUnit.sv ====
// Execute, writeback and halt state
`timescale 1ns/1ps
`include "wisc_config.svh"

module execUnit import isaPkg::*, ctrlPkg::*; (
	input logic clk,
	input logic rstN,
	input logic issue,
	input instr_u instr,
	input logic regWrite,
	input logic useImm,
	input logic invB,
	input logic halt,
	input logic isSet,
	input aluOp_e aluOp,
	input shiftOp_e shiftOp,
	input resSel_e resSel,
	input destSel_e destSel,
	input logic [1:0] setKind,
	input logic [`DATA_W-1:0] rsVal,
	input logic [`DATA_W-1:0] rtVal,
	input logic [`DATA_W-1:0] immVal,
	output logic wrEn,
	output logic [`REG_AW-1:0] wrAddr,
	output logic [`DATA_W-1:0] wrData,
	output logic halted,
	output logic lastSkipped
);

	logic [`DATA_W-1:0] opB;
	logic [`DATA_W-1:0] aluRes;
	logic [`DATA_W-1:0] shiftRes;
	logic [`DATA_W-1:0] btrRes;
	logic [2*`DATA_W-1:0] rotL;
	logic [2*`DATA_W-1:0] rotR;
	logic [3:0] shAmt;
	logic [`DATA_W:0] carrySum;
	logic setBit;

	assign opB = (useImm ? immVal : rtVal) ^ {`DATA_W{invB}};

	// Reversed subtract for subi and sub, andn relies on invB
	always_comb begin
		case (aluOp)
			add: aluRes = rsVal + opB;
			subFromImm, sub: aluRes = opB - rsVal;
			xorOp: aluRes = rsVal ^ opB;
			andOp, andnOp: aluRes = rsVal & opB;
			default: aluRes = opB;
		endcase
	end

	// Rotates through a doubled word
	assign shAmt = opB[3:0];
	assign rotL = {rsVal, rsVal} << shAmt;
	assign rotR = {rsVal, rsVal} >> shAmt;

	always_comb begin
		case (shiftOp)
			rol: shiftRes = rotL[2*`DATA_W-1:`DATA_W];
			sll: shiftRes = rsVal << shAmt;
			ror: shiftRes = rotR[`DATA_W-1:0];
			default: shiftRes = rsVal >> shAmt;
		endcase
	end

	assign carrySum = {1'b0, rsVal} + {1'b0, rtVal};

	always_comb begin
		case (setKind)
			2'd0: setBit = rsVal == rtVal;
			2'd1: setBit = $signed(rsVal) < $signed(rtVal);
			2'd2: setBit = $signed(rsVal) <= $signed(rtVal);
			default: setBit = carrySum[`DATA_W];
		endcase
	end

	always_comb begin
		for (int i = 0; i < `DATA_W; i++) begin
			btrRes[i] = rsVal[`DATA_W-1-i];
		end
	end

	always_comb begin
		case (resSel)
			alu: wrData = aluRes;
			shift: wrData = shiftRes;
			setCond: wrData = {{(`DATA_W-1){1'b0}}, isSet & setBit};
			lbi: wrData = immVal;
			slbi: wrData = {rsVal[7:0], immVal[7:0]};
			btr: wrData = btrRes;
			default: wrData = '0;
		endcase
	end

	always_comb begin
		case (destSel)
			fromRd2: wrAddr = instr.rView.rd;
			fromRs: wrAddr = instr.iOne.rs;
			default: wrAddr = instr.iOne.rd;
		endcase
	end

	assign wrEn = issue & regWrite & ~halted;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			halted <= 1'b0;
			lastSkipped <= 1'b0;
		end else if (issue) begin
			if (halt) begin
				halted <= 1'b1;
			end
			lastSkipped <= ~(regWrite & ~halted);
		end
	end

	assert property (@(posedge clk) disable iff (!rstN) halted |-> !wrEn)
		else $error("execUnit: register write after halt");

endmodule

// ==== wiscSlice.sv ====
// Decode and execute slice with Wishbone slave
`timescale 1ns/1ps
`include "wisc_config.svh"

module wiscSlice import isaPkg::*, ctrlPkg::*; (
	input logic clk,
	input logic rstN,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [`WB_AW-1:0] adr,
	input logic [`DATA_W-1:0] datIn,
	input logic [1:0] sel,
	output logic [`DATA_W-1:0] datOut,
	output logic ack
);

	instr_u instrWord;
	instr_u opInstr;
	logic reqValid;
	logic rdActive;
	logic issue;
	logic [`WB_AW-1:0] regSel;
	logic [7:0] issueCount;
	logic [`DATA_W-1:0] status;
	logic [`DATA_W-1:0] readMux;

	logic regWrite, useImm, signExt, immWide, invB, halt, isSet;
	aluOp_e aluOp;
	shiftOp_e shiftOp;
	resSel_e resSel;
	destSel_e destSel;
	logic [1:0] setKind;
	logic [`DATA_W-1:0] rsVal, rtVal, immVal;
	logic wrEn;
	logic [`REG_AW-1:0] wrAddr;
	logic [`DATA_W-1:0] wrData;
	logic halted, lastSkipped;

	assign instrWord = datIn;
	assign reqValid = cyc & stb & ~ack;
	assign rdActive = cyc & stb & ~we;
	assign issue = reqValid & we & (adr == '0);
	assign regSel = adr - 1'b1;

	// Host reads borrow the rs port
	always_comb begin
		opInstr = instrWord;
		if (rdActive) begin
			opInstr = '0;
			opInstr.iOne.rs = regSel[`REG_AW-1:0];
		end
	end

	assign status = {issueCount, 6'b0, lastSkipped, halted};

	always_comb begin
		if (adr == '0) begin
			readMux = status;
		end else if (adr <= `WB_AW'(`REG_COUNT)) begin
			readMux = rsVal;
		end else begin
			readMux = '0;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			ack <= 1'b0;
			issueCount <= '0;
		end else begin
			ack <= reqValid;
			if (issue) begin
				issueCount <= issueCount + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reqValid && !we) begin
			datOut <= readMux;
		end
	end

	control u_control (
		.instr(instrWord), .regWrite, .useImm, .signExt, .immWide, .invB, .halt,
		.isSet, .aluOp, .shiftOp, .resSel, .destSel, .setKind
	);

	operandUnit u_operandUnit (
		.clk, .rstN, .instr(opInstr), .signExt, .immWide, .wrEn, .wrAddr, .wrData,
		.rsVal, .rtVal, .immVal
	);

	execUnit u_execUnit (
		.clk, .rstN, .issue, .instr(instrWord), .regWrite, .useImm, .invB, .halt,
		.isSet, .aluOp, .shiftOp, .resSel, .destSel, .setKind, .rsVal, .rtVal,
		.immVal, .wrEn, .wrAddr, .wrData, .halted, .lastSkipped
	);

	// Single-cycle ack only after a fresh request
	assert property (@(posedge clk) disable iff (!rstN) ack |-> $past(cyc && stb && !ack))
		else $error("wiscSlice: ack without a pending request");

endmodule

// ==== tbChecker.sv ====
// Bus monitor and reference model
`timescale 1ns/1ps
`include "wisc_config.svh"

module tbChecker import isaPkg::*; (
	input logic clk,
	input logic rstN,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [`WB_AW-1:0] adr,
	input logic [`DATA_W-1:0] datIn,
	input logic [`DATA_W-1:0] datOut,
	input logic ack,
	input logic [2:0] testId,
	output int valueErrs,
	output int protoErrs
);

	logic [15:0] modelRegs [8];
	logic modelHalted;
	logic modelSkipped;
	logic [7:0] modelCount;
	logic pending;
	logic reqWe;
	logic [`WB_AW-1:0] reqAdr;
	logic [`DATA_W-1:0] reqDat;
	logic [2:0] reqTest;

	initial begin
		valueErrs = 0;
		protoErrs = 0;
	end

	function automatic string testName(input logic [2:0] id);
		case (id)
			3'd1: return "resetState";
			3'd2: return "preload";
			3'd3: return "randomOps";
			3'd4: return "skippedOps";
			3'd5: return "haltState";
			3'd6: return "addressMap";
			default: return "noTest";
		endcase
	endfunction

	// Steps one bit at a time in the ISA shift encoding
	function automatic logic [15:0] shiftModel(input logic [15:0] val, input logic [3:0] amt,
		input logic [1:0] kind);
		logic [15:0] r;
		r = val;
		for (int i = 0; i < amt; i++) begin
			case (kind)
				2'b00: r = {r[14:0], r[15]};
				2'b01: r = {r[14:0], 1'b0};
				2'b10: r = {r[0], r[15:1]};
				default: r = {1'b0, r[15:1]};
			endcase
		end
		return r;
	endfunction

	function automatic logic [15:0] reverseBits(input logic [15:0] val);
		logic [15:0] r;
		for (int i = 0; i < 16; i++) begin
			r[15-i] = val[i];
		end
		return r;
	endfunction

	task automatic applyInstr(input logic [15:0] w);
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] imm5s;
		logic [15:0] imm5z;
		logic [15:0] res;
		logic [16:0] sum;
		logic [2:0] dest;
		logic wr;
		a = modelRegs[w[10:8]];
		b = modelRegs[w[7:5]];
		imm5s = {{11{w[4]}}, w[4:0]};
		imm5z = {11'b0, w[4:0]};
		res = '0;
		wr = 1'b1;
		// R-format destination unless overridden
		dest = w[4:2];
		case (opcode_e'(w[15:11]))
			opAddi: begin
				res = a + imm5s;
				dest = w[7:5];
			end
			opSubi: begin
				res = imm5s - a;
				dest = w[7:5];
			end
			opXori: begin
				res = a ^ imm5z;
				dest = w[7:5];
			end
			opAndi: begin
				res = a & imm5z;
				dest = w[7:5];
			end
			opRoli, opSlli, opRori, opSrli: begin
				res = shiftModel(a, w[3:0], w[12:11]);
				dest = w[7:5];
			end
			opSlbi: begin
				res = (a << 8) | {8'b0, w[7:0]};
				dest = w[10:8];
			end
			opLbi: begin
				res = {{8{w[7]}}, w[7:0]};
				dest = w[10:8];
			end
			opBtr: res = reverseBits(a);
			opShiftR: res = shiftModel(a, b[3:0], w[1:0]);
			opAluR: begin
				case (w[1:0])
					2'b00: res = a + b;
					2'b01: res = b - a;
					2'b10: res = a ^ b;
					default: res = a & ~b;
				endcase
			end
			opSeq: res = {15'b0, a == b};
			opSlt: res = {15'b0, $signed(a) < $signed(b)};
			opSle: res = {15'b0, $signed(a) <= $signed(b)};
			opSco: begin
				sum = {1'b0, a} + {1'b0, b};
				res = {15'b0, sum[16]};
			end
			default: wr = 1'b0;
		endcase
		if (modelHalted) begin
			modelSkipped = 1'b1;
		end else if (opcode_e'(w[15:11]) == opHalt) begin
			modelHalted = 1'b1;
			modelSkipped = 1'b1;
		end else begin
			modelSkipped = !wr;
			if (wr) begin
				modelRegs[dest] = res;
			end
		end
		modelCount++;
	endtask

	task automatic checkRead();
		logic [15:0] expected;
		logic [2:0] regIdx;
		regIdx = reqAdr[2:0] - 3'd1;
		if (reqAdr == '0) begin
			expected = {modelCount, 6'b0, modelSkipped, modelHalted};
		end else if (reqAdr <= 4'd8) begin
			expected = modelRegs[regIdx];
		end else begin
			expected = '0;
		end
		if (datOut !== expected) begin
			$display("[FAIL] %s: read of address %0d expected %h, actual %h",
				testName(reqTest), reqAdr, expected, datOut);
			valueErrs++;
		end
	endtask

	// Inputs change on the falling edge, so both sides are settled here
	always @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < 8; i++) begin
				modelRegs[i] = '0;
			end
			modelHalted = 1'b0;
			modelSkipped = 1'b0;
			modelCount = '0;
			pending = 1'b0;
		end else begin
			if (pending) begin
				if (!ack) begin
					$display("Bus cycle to address %0d got no ack one cycle after the request",
						reqAdr);
					protoErrs++;
				end else if (reqWe) begin
					if (reqAdr == '0) begin
						applyInstr(reqDat);
					end
				end else begin
					checkRead();
				end
				pending = 1'b0;
			end else if (ack) begin
				$display("An ack came with no bus request pending");
				protoErrs++;
			end
			if (cyc && stb && !ack) begin
				pending = 1'b1;
				reqWe = we;
				reqAdr = adr;
				reqDat = datIn;
				reqTest = testId;
			end
		end
	end

endmodule

// ==== tbTop.sv ====
// Testbench for the decode and execute slice
`timescale 1ns/1ps
`include "wisc_config.svh"

module tbTop import isaPkg::*; ();

	localparam int numRandom = 400;
	localparam int numAfterHalt = 20;
	// Reset 9, preload 33, random, skipped 36, address map 30, halt 11 plus the tail
	localparam int busCycles = 9 + 33 + 2 * numRandom + 36 + 30 + 11 + numAfterHalt;
	localparam int cycleLimit = busCycles * 2 + 100;

	logic clk = 1'b0;
	logic rstN;
	logic cyc;
	logic stb;
	logic we;
	logic [`WB_AW-1:0] adr;
	logic [`DATA_W-1:0] datIn;
	logic [1:0] sel;
	logic [`DATA_W-1:0] datOut;
	logic ack;
	logic [2:0] testId;
	int valueErrs;
	int protoErrs;
	int driverErrs = 0;
	int cycleCount = 0;
	logic [31:0] rngState;

	opcode_e computeOps [16] = '{opAddi, opSubi, opXori, opAndi, opRoli, opSlli, opRori,
		opSrli, opBtr, opShiftR, opAluR, opAluR, opSeq, opSlt, opSle, opSco};
	opcode_e skipOps [14] = '{opNop, opSiic, opRti, opJ, opJr, opJal, opJalr, opBeqz,
		opBnez, opBltz, opBgez, opSt, opLd, opStu};

	always #50 clk = ~clk;

	wiscSlice dut (
		.clk, .rstN, .cyc, .stb, .we, .adr, .datIn, .sel, .datOut, .ack
	);

	tbChecker chk (
		.clk, .rstN, .cyc, .stb, .we, .adr, .datIn, .datOut, .ack, .testId,
		.valueErrs, .protoErrs
	);

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount > cycleLimit) begin
			$display("Timeout: the run went past its limit of %0d cycles", cycleLimit);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] nextRand();
		rngState ^= rngState << 13;
		rngState ^= rngState >> 17;
		rngState ^= rngState << 5;
		return rngState;
	endfunction

	// Host side of one classic cycle held until ack
	task automatic busXfer(input logic wr, input logic [`WB_AW-1:0] a,
		input logic [`DATA_W-1:0] d);
		int waits;
		@(negedge clk);
		cyc = 1'b1;
		stb = 1'b1;
		we = wr;
		adr = a;
		datIn = d;
		waits = 0;
		@(negedge clk);
		while (!ack && waits < 3) begin
			@(negedge clk);
			waits++;
		end
		if (!ack) begin
			$display("Host gave up on address %0d after waiting for an ack", a);
			driverErrs++;
		end
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
	endtask

	task automatic issueWord(input logic [15:0] w);
		busXfer(1'b1, '0, w);
	endtask

	task automatic readAddr(input logic [`WB_AW-1:0] a);
		busXfer(1'b0, a, '0);
	endtask

	task automatic readAllRegs();
		for (int i = 0; i < 8; i++) begin
			readAddr(4'(i + 1));
		end
	endtask

	initial begin
		logic [31:0] rnd;
		opcode_e op;
		logic [15:0] word;
		logic [2:0] dest;
		rstN = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		datIn = '0;
		sel = 2'b11;
		testId = 3'd0;
		rngState = 32'd86777;
		repeat (2) @(negedge clk);
		rstN = 1'b1;

		testId = 3'd1;
		readAllRegs();
		readAddr(4'd0);

		testId = 3'd2;
		for (int i = 0; i < 8; i++) begin
			rnd = nextRand();
			issueWord({opLbi, 3'(i), rnd[7:0]});
		end
		// Sign extension is visible only before slbi
		readAllRegs();
		for (int i = 0; i < 8; i++) begin
			rnd = nextRand();
			issueWord({opSlbi, 3'(i), rnd[15:8]});
		end
		readAllRegs();
		readAddr(4'd0);

		testId = 3'd3;
		for (int n = 0; n < numRandom; n++) begin
			rnd = nextRand();
			op = computeOps[rnd[19:16]];
			word = {op, rnd[10:0]};
			issueWord(word);
			// I-format results land in bits 7:5, R-format in 4:2
			if (op inside {opAddi, opSubi, opXori, opAndi, opRoli, opSlli, opRori, opSrli}) begin
				dest = word[7:5];
			end else begin
				dest = word[4:2];
			end
			readAddr(4'(dest) + 4'd1);
		end

		testId = 3'd4;
		for (int i = 0; i < 14; i++) begin
			rnd = nextRand();
			issueWord({skipOps[i], rnd[10:0]});
			readAddr(4'd0);
		end
		readAllRegs();

		testId = 3'd6;
		for (int a = 9; a < 16; a++) begin
			readAddr(4'(a));
		end
		for (int a = 1; a < 16; a++) begin
			rnd = nextRand();
			busXfer(1'b1, 4'(a), rnd[15:0]);
		end
		readAllRegs();

		testId = 3'd5;
		rnd = nextRand();
		issueWord({opHalt, rnd[10:0]});
		readAddr(4'd0);
		for (int n = 0; n < numAfterHalt; n++) begin
			rnd = nextRand();
			issueWord(rnd[15:0]);
		end
		readAllRegs();
		readAddr(4'd0);

		// Let the monitor see the last ack
		repeat (2) @(negedge clk);
		$display("Errors: %0d value, %0d protocol, %0d bus driver",
			valueErrs, protoErrs, driverErrs);
		if (valueErrs + protoErrs + driverErrs == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+.
isaPkg.sv
ctrlPkg.sv
control.sv
operandUnit.sv
execUnit.sv
wiscSlice.sv
tbChecker.sv
tbTop.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the slice testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module tbTop -o simv
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q "^ALL TESTS PASSED$" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1
